//--- verilog/riscv_icu_cfg.svh
`ifndef RISCV_ICU_CFG_SVH
`define RISCV_ICU_CFG_SVH

// integer register width.
`define RISCV_XLEN 64

// iteration counter, must reach XLEN.
`define RISCV_CNT_W 7

`endif

//--- verilog/riscv_icu_pkg.sv
package riscv_icu_pkg;

    // alu opcodes, W forms work on the low word.
    typedef enum logic [5:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_LUI, ALU_ADDW,
        ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW
    } alu_op_e;

    // branch conditions.
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT,
        BR_BGE, BR_BLTU, BR_BGEU, BR_JAL
    } branch_cond_e;

    typedef enum logic [3:0] {
        MUL_NONE, MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU, MUL_MULW
    } mul_op_e;

    typedef enum logic [3:0] {
        DIV_NONE, DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU,
        DIV_DIVW, DIV_DIVUW, DIV_REMW, DIV_REMUW
    } div_op_e;

    // result select at the unit output.
    typedef enum logic [1:0] {
        SEL_MUL = 2'd0,
        SEL_DIV = 2'd1,
        SEL_ALU = 2'd2
    } func_sel_e;

    typedef enum logic [1:0] {MS_IDLE, MS_RUN, MS_DONE} mul_state_e;

    typedef enum logic [1:0] {DS_IDLE, DS_RUN, DS_FIX, DS_DONE} div_state_e;

endpackage

//--- verilog/riscv_md_if.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

interface riscv_md_if;
    import riscv_icu_pkg::*;

    // operands shared by both long-latency units.
    logic signed [`RISCV_XLEN-1:0] rs1data;
    logic signed [`RISCV_XLEN-1:0] rs2data;
    mul_op_e                       mulctrl;
    div_op_e                       divctrl;

    modport issue (output rs1data, rs2data, mulctrl, divctrl);

    modport mul (input rs1data, rs2data, mulctrl);

    modport div (input rs1data, rs2data, divctrl);

endinterface

//--- verilog/riscv_alu.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_alu (
    input  riscv_icu_pkg::alu_op_e        i_riscv_alu_ctrl,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_alu_rs1data,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_alu_rs2data,
    output logic signed [`RISCV_XLEN-1:0] o_riscv_alu_result
);
    import riscv_icu_pkg::*;

    localparam int XLEN = `RISCV_XLEN;
    localparam int HALF = XLEN / 2;

    logic [5:0]      shamt;
    logic [4:0]      shamt_w;
    logic [HALF-1:0] rs1_w;
    logic [HALF-1:0] rs2_w;
    logic [HALF-1:0] res_w;
    logic            slt;
    logic            sltu;

    assign shamt   = i_riscv_alu_rs2data[5:0];
    assign shamt_w = i_riscv_alu_rs2data[4:0];
    assign rs1_w   = i_riscv_alu_rs1data[HALF-1:0];
    assign rs2_w   = i_riscv_alu_rs2data[HALF-1:0];
    assign slt     = i_riscv_alu_rs1data < i_riscv_alu_rs2data;
    assign sltu    = $unsigned(i_riscv_alu_rs1data) < $unsigned(i_riscv_alu_rs2data);

    // low word result for the W forms.
    always_comb begin
        case (i_riscv_alu_ctrl)
            ALU_SUBW: res_w = rs1_w - rs2_w;
            ALU_SLLW: res_w = rs1_w << shamt_w;
            ALU_SRLW: res_w = rs1_w >> shamt_w;
            ALU_SRAW: res_w = $signed(rs1_w) >>> shamt_w;
            default:  res_w = rs1_w + rs2_w;
        endcase
    end

    always_comb begin
        case (i_riscv_alu_ctrl)
            ALU_ADD:  o_riscv_alu_result = i_riscv_alu_rs1data + i_riscv_alu_rs2data;
            ALU_SUB:  o_riscv_alu_result = i_riscv_alu_rs1data - i_riscv_alu_rs2data;
            ALU_SLL:  o_riscv_alu_result = i_riscv_alu_rs1data << shamt;
            ALU_SLT:  o_riscv_alu_result = {{(XLEN-1){1'b0}}, slt};
            ALU_SLTU: o_riscv_alu_result = {{(XLEN-1){1'b0}}, sltu};
            ALU_XOR:  o_riscv_alu_result = i_riscv_alu_rs1data ^ i_riscv_alu_rs2data;
            ALU_SRL:  o_riscv_alu_result = $unsigned(i_riscv_alu_rs1data) >> shamt;
            ALU_SRA:  o_riscv_alu_result = i_riscv_alu_rs1data >>> shamt;
            ALU_OR:   o_riscv_alu_result = i_riscv_alu_rs1data | i_riscv_alu_rs2data;
            ALU_AND:  o_riscv_alu_result = i_riscv_alu_rs1data & i_riscv_alu_rs2data;
            // upper immediate arrives on rs2.
            ALU_LUI:  o_riscv_alu_result = i_riscv_alu_rs2data;
            ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW: begin
                o_riscv_alu_result = {{HALF{res_w[HALF-1]}}, res_w};
            end
            default:  o_riscv_alu_result = '0;
        endcase
    end

endmodule

//--- verilog/riscv_branch.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_branch (
    input  riscv_icu_pkg::branch_cond_e   i_riscv_branch_cond,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_branch_rs1data,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_branch_rs2data,
    output logic                          o_riscv_branch_taken
);
    import riscv_icu_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = i_riscv_branch_rs1data == i_riscv_branch_rs2data;
    assign lt  = i_riscv_branch_rs1data < i_riscv_branch_rs2data;
    assign ltu = $unsigned(i_riscv_branch_rs1data) < $unsigned(i_riscv_branch_rs2data);

    always_comb begin
        case (i_riscv_branch_cond)
            BR_BEQ:  o_riscv_branch_taken = eq;
            BR_BNE:  o_riscv_branch_taken = !eq;
            BR_BLT:  o_riscv_branch_taken = lt;
            BR_BGE:  o_riscv_branch_taken = !lt;
            BR_BLTU: o_riscv_branch_taken = ltu;
            BR_BGEU: o_riscv_branch_taken = !ltu;
            BR_JAL:  o_riscv_branch_taken = 1'b1;
            default: o_riscv_branch_taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/riscv_multiplier.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_multiplier (
    input  logic                          i_riscv_mul_clk,
    input  logic                          i_reset,
    riscv_md_if.mul                       md,
    output logic                          o_riscv_mul_valid,
    output logic                          o_riscv_mul_busy,
    output logic signed [`RISCV_XLEN-1:0] o_riscv_mul_product
);
    import riscv_icu_pkg::*;

    localparam int XLEN  = `RISCV_XLEN;
    localparam int CNT_W = `RISCV_CNT_W;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XLEN);

    mul_state_e        state_q;
    logic [CNT_W-1:0]  cnt_q;
    mul_op_e           op_q;
    logic              neg_q;
    logic [XLEN-1:0]   mcand_q;
    logic [2*XLEN-1:0] acc_q;
    logic [XLEN-1:0]   product_q;
    logic              accept;
    logic              a_signed;
    logic              b_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [XLEN:0]     sum;
    logic [2*XLEN-1:0] acc_fix;

    assign accept = (state_q == MS_IDLE) && (md.mulctrl != MUL_NONE);

    // operand signedness per opcode.
    always_comb begin
        case (md.mulctrl)
            MUL_MUL, MUL_MULH, MUL_MULW: {a_signed, b_signed} = 2'b11;
            MUL_MULHSU:                  {a_signed, b_signed} = 2'b10;
            default:                     {a_signed, b_signed} = 2'b00;
        endcase
    end

    assign a_neg = a_signed & md.rs1data[XLEN-1];
    assign b_neg = b_signed & md.rs2data[XLEN-1];
    assign mag_a = a_neg ? -md.rs1data : md.rs1data;
    assign mag_b = b_neg ? -md.rs2data : md.rs2data;

    // multiplier bits shift out of the low half of the accumulator.
    assign sum     = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mcand_q} : '0);
    assign acc_fix = neg_q ? -acc_q : acc_q;

    always_ff @(posedge i_riscv_mul_clk) begin
        if (i_reset) begin
            state_q <= MS_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MS_IDLE: begin
                    cnt_q <= '0;
                    if (accept) state_q <= MS_RUN;
                end
                MS_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_LAST) state_q <= MS_DONE;
                end
                default: state_q <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_riscv_mul_clk) begin
        if (accept) begin
            op_q    <= md.mulctrl;
            neg_q   <= a_neg ^ b_neg;
            mcand_q <= mag_a;
            acc_q   <= {{XLEN{1'b0}}, mag_b};
        end else if (state_q == MS_RUN && cnt_q != CNT_LAST) begin
            acc_q <= {sum, acc_q[XLEN-1:1]};
        end else if (state_q == MS_RUN) begin
            // sign and half select.
            case (op_q)
                MUL_MUL:  product_q <= acc_fix[XLEN-1:0];
                MUL_MULW: product_q <= {{(XLEN/2){acc_fix[XLEN/2-1]}}, acc_fix[XLEN/2-1:0]};
                default:  product_q <= acc_fix[2*XLEN-1:XLEN];
            endcase
        end
    end

    assign o_riscv_mul_valid   = state_q == MS_DONE;
    assign o_riscv_mul_busy    = state_q != MS_IDLE;
    assign o_riscv_mul_product = product_q;

endmodule

//--- verilog/riscv_divider.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_divider (
    input  logic                          i_riscv_div_clk,
    input  logic                          i_reset,
    riscv_md_if.div                       md,
    output logic                          o_riscv_div_valid,
    output logic                          o_riscv_div_busy,
    output logic signed [`RISCV_XLEN-1:0] o_riscv_div_result
);
    import riscv_icu_pkg::*;

    localparam int XLEN  = `RISCV_XLEN;
    localparam int HALF  = XLEN / 2;
    localparam int CNT_W = `RISCV_CNT_W;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(XLEN);

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             w_q, sgn_q, rem_op_q, zero_q, ovf_q, neg_q_q, neg_r_q;
    logic [XLEN-1:0]  a_q, b_q, quo_q, rem_q, dvs_q, result_q;
    logic             accept, w_op, sgn_op, special;
    logic [XLEN-1:0]  a_ext, b_ext, int_min, q_fix, r_fix;
    logic [XLEN:0]    rem_shift, diff;

    function automatic logic [XLEN-1:0] wfix(input logic w, input logic [XLEN-1:0] v);
        return w ? {{HALF{v[HALF-1]}}, v[HALF-1:0]} : v;
    endfunction

    assign accept = (state_q == DS_IDLE) && (md.divctrl != DIV_NONE);
    assign w_op   = md.divctrl inside {DIV_DIVW, DIV_DIVUW, DIV_REMW, DIV_REMUW};
    assign sgn_op = md.divctrl inside {DIV_DIV, DIV_REM, DIV_DIVW, DIV_REMW};

    // W forms see the low word, sign or zero extended.
    assign a_ext   = !w_op ? md.rs1data :
                     {{HALF{sgn_op & md.rs1data[HALF-1]}}, md.rs1data[HALF-1:0]};
    assign b_ext   = !w_op ? md.rs2data :
                     {{HALF{sgn_op & md.rs2data[HALF-1]}}, md.rs2data[HALF-1:0]};
    assign int_min = w_op ? {{(HALF+1){1'b1}}, {(HALF-1){1'b0}}} : {1'b1, {(XLEN-1){1'b0}}};

    assign special   = zero_q | ovf_q;
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvs_q};
    assign q_fix     = neg_q_q ? -quo_q : quo_q;
    assign r_fix     = neg_r_q ? -rem_q : rem_q;

    always_ff @(posedge i_riscv_div_clk) begin
        if (i_reset) begin
            state_q <= DS_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DS_IDLE: begin
                    cnt_q <= '0;
                    if (accept) state_q <= DS_RUN;
                end
                DS_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    // early exit from the setup cycle.
                    if (cnt_q == '0 && special) state_q <= DS_DONE;
                    else if (cnt_q == CNT_LAST) state_q <= DS_FIX;
                end
                DS_FIX:  state_q <= DS_DONE;
                default: state_q <= DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_riscv_div_clk) begin
        if (accept) begin
            a_q      <= a_ext;
            b_q      <= b_ext;
            w_q      <= w_op;
            sgn_q    <= sgn_op;
            rem_op_q <= md.divctrl inside {DIV_REM, DIV_REMU, DIV_REMW, DIV_REMUW};
            zero_q   <= b_ext == '0;
            ovf_q    <= sgn_op && (b_ext == '1) && (a_ext == int_min);
        end else if (state_q == DS_RUN && cnt_q == '0) begin
            if (zero_q) begin
                result_q <= wfix(w_q, rem_op_q ? a_q : '1);
            end else if (ovf_q) begin
                result_q <= wfix(w_q, rem_op_q ? '0 : a_q);
            end
            rem_q   <= '0;
            quo_q   <= (sgn_q & a_q[XLEN-1]) ? -a_q : a_q;
            dvs_q   <= (sgn_q & b_q[XLEN-1]) ? -b_q : b_q;
            neg_q_q <= sgn_q & (a_q[XLEN-1] ^ b_q[XLEN-1]);
            neg_r_q <= sgn_q & a_q[XLEN-1];
        end else if (state_q == DS_RUN) begin
            // restore when the trial subtract goes negative.
            rem_q <= diff[XLEN] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], !diff[XLEN]};
        end else if (state_q == DS_FIX) begin
            result_q <= wfix(w_q, rem_op_q ? r_fix : q_fix);
        end
    end

    assign o_riscv_div_valid  = state_q == DS_DONE;
    assign o_riscv_div_busy   = state_q != DS_IDLE;
    assign o_riscv_div_result = result_q;

endmodule

//--- verilog/riscv_icu.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_icu (
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_icu_rs1data,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_icu_rs2data,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_icu_alurs1data,
    input  logic signed [`RISCV_XLEN-1:0] i_riscv_icu_alurs2data,
    input  riscv_icu_pkg::branch_cond_e   i_riscv_icu_bcond,
    input  riscv_icu_pkg::mul_op_e        i_riscv_icu_mulctrl,
    input  riscv_icu_pkg::div_op_e        i_riscv_icu_divctrl,
    input  riscv_icu_pkg::alu_op_e        i_riscv_icu_aluctrl,
    input  riscv_icu_pkg::func_sel_e      i_riscv_icu_funcsel,
    input  logic                          i_riscv_icu_clk,
    input  logic                          i_reset,
    output logic                          o_riscv_branch_taken,
    output logic                          o_riscv_icu_valid,
    output logic                          o_riscv_icu_busy,
    output logic signed [`RISCV_XLEN-1:0] o_riscv_icu_result
);
    import riscv_icu_pkg::*;

    logic                          mul_valid, div_valid;
    logic                          mul_busy, div_busy;
    logic signed [`RISCV_XLEN-1:0] alu_result, mul_result, div_result;

    riscv_md_if md_if ();

    // long-latency units share the alu operands.
    assign md_if.rs1data = i_riscv_icu_alurs1data;
    assign md_if.rs2data = i_riscv_icu_alurs2data;
    assign md_if.mulctrl = i_riscv_icu_mulctrl;
    assign md_if.divctrl = i_riscv_icu_divctrl;

    riscv_alu u_alu (
        .i_riscv_alu_ctrl    (i_riscv_icu_aluctrl),
        .i_riscv_alu_rs1data (i_riscv_icu_alurs1data),
        .i_riscv_alu_rs2data (i_riscv_icu_alurs2data),
        .o_riscv_alu_result  (alu_result)
    );

    riscv_branch u_branch (
        .i_riscv_branch_cond    (i_riscv_icu_bcond),
        .i_riscv_branch_rs1data (i_riscv_icu_rs1data),
        .i_riscv_branch_rs2data (i_riscv_icu_rs2data),
        .o_riscv_branch_taken   (o_riscv_branch_taken)
    );

    riscv_multiplier u_mul (
        .i_riscv_mul_clk     (i_riscv_icu_clk),
        .i_reset             (i_reset),
        .md                  (md_if.mul),
        .o_riscv_mul_valid   (mul_valid),
        .o_riscv_mul_busy    (mul_busy),
        .o_riscv_mul_product (mul_result)
    );

    riscv_divider u_div (
        .i_riscv_div_clk    (i_riscv_icu_clk),
        .i_reset            (i_reset),
        .md                 (md_if.div),
        .o_riscv_div_valid  (div_valid),
        .o_riscv_div_busy   (div_busy),
        .o_riscv_div_result (div_result)
    );

    assign o_riscv_icu_valid = mul_valid | div_valid;
    assign o_riscv_icu_busy  = mul_busy | div_busy;

    // unused select code gives zero.
    always_comb begin
        case (i_riscv_icu_funcsel)
            SEL_MUL: o_riscv_icu_result = mul_result;
            SEL_DIV: o_riscv_icu_result = div_result;
            SEL_ALU: o_riscv_icu_result = alu_result;
            default: o_riscv_icu_result = '0;
        endcase
    end

endmodule

//--- dv/riscv_icu_assert.sv
`timescale 1ns/1ps

module riscv_icu_assert (
    input logic                     i_clk,
    input logic                     i_reset,
    input logic                     i_valid,
    input logic                     i_busy,
    input riscv_icu_pkg::mul_op_e   i_mulctrl,
    input logic                     i_mul_busy,
    input logic                     i_mul_valid
);
    import riscv_icu_pkg::*;

    logic mul_accept;

    assign mul_accept = !i_mul_busy && (i_mulctrl != MUL_NONE);

    // valid is a single-cycle pulse.
    valid_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |=> !i_valid)
        else $error("valid high for two cycles in a row");

    reset_idle: assert property (@(posedge i_clk)
        i_reset |=> (!i_valid && !i_busy))
        else $error("valid or busy high after reset");

    // 64 iterations, select cycle, then DONE.
    mul_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        mul_accept |-> ##1 (!i_mul_valid) [*65] ##1 i_mul_valid)
        else $error("multiplier valid not 66 cycles after accept");

endmodule

bind riscv_icu riscv_icu_assert u_assert (
    .i_clk       (i_riscv_icu_clk),
    .i_reset     (i_reset),
    .i_valid     (o_riscv_icu_valid),
    .i_busy      (o_riscv_icu_busy),
    .i_mulctrl   (i_riscv_icu_mulctrl),
    .i_mul_busy  (mul_busy),
    .i_mul_valid (mul_valid)
);

//--- dv/riscv_icu_tb.sv
`timescale 1ns/1ps
`include "riscv_icu_cfg.svh"

module riscv_icu_tb;
    import riscv_icu_pkg::*;

    localparam int XLEN      = `RISCV_XLEN;
    localparam int LIMIT     = 200 * 70 + 2000;
    localparam int MUL_LAT   = 66;
    localparam logic [XLEN-1:0] MIN64 = {1'b1, {(XLEN-1){1'b0}}};

    logic                   clk;
    logic                   rst;
    logic signed [XLEN-1:0] rs1, rs2, alu1, alu2;
    branch_cond_e           bcond;
    mul_op_e                mulctrl;
    div_op_e                divctrl;
    alu_op_e                aluctrl;
    func_sel_e              funcsel;
    logic                   taken, valid, busy;
    logic signed [XLEN-1:0] result;

    int                     cycle = 0;
    int                     issue_cycle;
    int                     nvalid = 0;
    int                     value_errs = 0;
    int                     other_errs = 0;
    logic                   md_pending = 0;
    logic                   md_is_mul;
    logic signed [XLEN-1:0] exp_md;
    logic [XLEN-1:0]        edges [3];

    riscv_icu riscv_icu_inst (
        .i_riscv_icu_rs1data    (rs1),
        .i_riscv_icu_rs2data    (rs2),
        .i_riscv_icu_alurs1data (alu1),
        .i_riscv_icu_alurs2data (alu2),
        .i_riscv_icu_bcond      (bcond),
        .i_riscv_icu_mulctrl    (mulctrl),
        .i_riscv_icu_divctrl    (divctrl),
        .i_riscv_icu_aluctrl    (aluctrl),
        .i_riscv_icu_funcsel    (funcsel),
        .i_riscv_icu_clk        (clk),
        .i_reset                (rst),
        .o_riscv_branch_taken   (taken),
        .o_riscv_icu_valid      (valid),
        .o_riscv_icu_busy       (busy),
        .o_riscv_icu_result     (result)
    );

    initial begin
        clk = 0;
        forever #4 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] sext_word(input logic [XLEN-1:0] v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // expected value straight from the RISC-V definitions.
    function automatic logic signed [XLEN-1:0] ref_result(input func_sel_e sel,
            input alu_op_e aop, input mul_op_e mop, input div_op_e dop,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] pa, pb, p;
        logic [XLEN-1:0]          q, r, da, db;
        logic                     w, sgn;
        if (sel == SEL_ALU) begin
            case (aop)
                ALU_ADD:  return a + b;
                ALU_SUB:  return a - b;
                ALU_SLL:  return a << b[5:0];
                ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
                ALU_SLTU: return (a < b) ? 1 : 0;
                ALU_XOR:  return a ^ b;
                ALU_SRL:  return a >> b[5:0];
                ALU_SRA:  return $signed(a) >>> b[5:0];
                ALU_OR:   return a | b;
                ALU_AND:  return a & b;
                ALU_LUI:  return b;
                ALU_ADDW: return sext_word(a + b);
                ALU_SUBW: return sext_word(a - b);
                ALU_SLLW: return sext_word(a << b[4:0]);
                ALU_SRLW: return sext_word({32'b0, a[31:0]} >> b[4:0]);
                ALU_SRAW: return sext_word(sext_word(a) >>> b[4:0]);
                default:  return 0;
            endcase
        end else if (sel == SEL_MUL) begin
            pa = (mop == MUL_MULHU) ? {64'b0, a} : {{64{a[63]}}, a};
            pb = (mop == MUL_MULHU || mop == MUL_MULHSU) ? {64'b0, b} : {{64{b[63]}}, b};
            p  = pa * pb;
            case (mop)
                MUL_MUL:  return p[63:0];
                MUL_MULW: return sext_word(p[63:0]);
                default:  return p[127:64];
            endcase
        end else if (sel == SEL_DIV) begin
            w   = dop inside {DIV_DIVW, DIV_DIVUW, DIV_REMW, DIV_REMUW};
            sgn = dop inside {DIV_DIV, DIV_REM, DIV_DIVW, DIV_REMW};
            da  = !w ? a : (sgn ? sext_word(a) : {32'b0, a[31:0]});
            db  = !w ? b : (sgn ? sext_word(b) : {32'b0, b[31:0]});
            if (db == 0) begin
                q = '1;
                r = da;
            end else if (sgn && db == '1 && da == MIN64) begin
                q = da;
                r = 0;
            end else if (sgn) begin
                q = $signed(da) / $signed(db);
                r = $signed(da) % $signed(db);
            end else begin
                q = da / db;
                r = da % db;
            end
            q = (dop inside {DIV_REM, DIV_REMU, DIV_REMW, DIV_REMUW}) ? r : q;
            return w ? sext_word(q) : q;
        end
        return 0;
    endfunction

    function automatic logic ref_taken(input branch_cond_e c, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b);
        case (c)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            BR_JAL:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_result(input string what, input logic signed [XLEN-1:0] got,
            input logic signed [XLEN-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t: %s result %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_taken(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // compare process and cycle count for the timeout.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display(">>> FAIL");
            $finish;
        end else if (valid) begin
            nvalid++;
            if (!md_pending) begin
                other_errs++;
                $display("unexpected valid pulse at %0t", $time);
            end else begin
                check_result(md_is_mul ? "mul" : "div", result, exp_md);
                if (md_is_mul && cycle - issue_cycle != MUL_LAT) begin
                    other_errs++;
                    $display("multiplier valid came %0d cycles after issue",
                             cycle - issue_cycle);
                end
                md_pending = 0;
            end
        end
    end

    task automatic alu_op(input alu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        @(negedge clk);
        aluctrl = op;
        funcsel = SEL_ALU;
        alu1    = a;
        alu2    = b;
        #1;
        check_result(op.name(), result, ref_result(SEL_ALU, op, MUL_NONE, DIV_NONE, a, b));
    endtask

    task automatic branch_op(input branch_cond_e c, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b);
        @(negedge clk);
        bcond = c;
        rs1   = a;
        rs2   = b;
        #1;
        check_taken(c.name(), taken, ref_taken(c, a, b));
    endtask

    // issue one long operation and wait for its valid pulse.
    task automatic md_op(input mul_op_e mop, input div_op_e dop, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b, input logic retry_busy);
        int n;
        @(negedge clk);
        funcsel     = (mop != MUL_NONE) ? SEL_MUL : SEL_DIV;
        mulctrl     = mop;
        divctrl     = dop;
        alu1        = a;
        alu2        = b;
        exp_md      = ref_result(funcsel, ALU_ADD, mop, dop, a, b);
        md_is_mul   = mop != MUL_NONE;
        issue_cycle = cycle + 1;
        md_pending  = 1;
        n           = nvalid;
        @(negedge clk);
        check_taken("busy after issue", busy, 1'b1);
        // a second request while busy must be dropped.
        alu1 = retry_busy ? rand64() : alu1;
        alu2 = retry_busy ? rand64() : alu2;
        if (!retry_busy) begin
            mulctrl = MUL_NONE;
            divctrl = DIV_NONE;
        end
        @(negedge clk);
        mulctrl = MUL_NONE;
        divctrl = DIV_NONE;
        for (int i = 0; i < 80 && nvalid == n; i++) @(negedge clk);
        if (nvalid == n) begin
            other_errs++;
            md_pending = 0;
            $display("valid never arrived for %s%s", mop.name(), dop.name());
        end else begin
            check_taken("busy after valid", busy, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'hf55b418d));
        rst = 1;
        rs1 = 0;
        rs2 = 0;
        alu1 = 0;
        alu2 = 0;
        bcond = BR_NONE;
        mulctrl = MUL_NONE;
        divctrl = DIV_NONE;
        aluctrl = ALU_ADD;
        funcsel = SEL_ALU;
        edges[0] = '0;
        edges[1] = '1;
        edges[2] = MIN64;
        repeat (8) @(negedge clk);
        rst = 0;
        #1;
        check_taken("valid after reset", valid, 1'b0);
        check_taken("busy after reset", busy, 1'b0);

        for (int k = 0; k < 16; k++) begin
            foreach (edges[i]) foreach (edges[j]) alu_op(alu_op_e'(k), edges[i], edges[j]);
            repeat (6) alu_op(alu_op_e'(k), rand64(), rand64());
        end

        // select code 3 reads as zero.
        @(negedge clk);
        funcsel = func_sel_e'(2'd3);
        #1;
        check_result("unused select", result, '0);

        for (int k = 0; k < 8; k++) begin
            logic [XLEN-1:0] v;
            v = rand64();
            branch_op(branch_cond_e'(k), v, v);
            branch_op(branch_cond_e'(k), v | MIN64, v & ~MIN64);
            branch_op(branch_cond_e'(k), v & ~MIN64, v | MIN64);
            repeat (4) branch_op(branch_cond_e'(k), rand64(), rand64());
        end

        for (int k = 1; k <= 5; k++) begin
            md_op(mul_op_e'(k), DIV_NONE, MIN64, '1, 0);
            repeat (4) md_op(mul_op_e'(k), DIV_NONE, rand64(), rand64(), 0);
        end

        for (int k = 1; k <= 8; k++) begin
            md_op(MUL_NONE, div_op_e'(k), rand64(), 0, 0);
            md_op(MUL_NONE, div_op_e'(k), MIN64, '1, 0);
            md_op(MUL_NONE, div_op_e'(k), {$urandom, 32'h80000000}, '1, 0);
            md_op(MUL_NONE, div_op_e'(k), rand64(), {{56{1'b1}}, 8'($urandom)}, 0);
            repeat (3) md_op(MUL_NONE, div_op_e'(k), rand64(), rand64(), 0);
        end

        md_op(MUL_MULHU, DIV_NONE, rand64(), rand64(), 1);
        md_op(MUL_NONE, DIV_DIVU, rand64(), 64'd7, 1);
        repeat (10) @(negedge clk);

        $display("errors: value %0d, other %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+verilog
verilog/riscv_icu_pkg.sv
verilog/riscv_md_if.sv
verilog/riscv_alu.sv
verilog/riscv_branch.sv
verilog/riscv_multiplier.sv
verilog/riscv_divider.sv
verilog/riscv_icu.sv
dv/riscv_icu_assert.sv
dv/riscv_icu_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= riscv_icu_tb
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
